/* all.f */
+incdir+include
hw/divsqrt_op_pkg.sv
hw/divsqrt_pipe_pkg.sv
hw/divsqrt_core_if.sv
hw/divsqrt_pipe_regs.sv
hw/divsqrt_ctrl.sv
hw/divsqrt_iter.sv
hw/divsqrt_top.sv
verif/divsqrt_chk.sv
verif/tb_divsqrt.sv

/* run_sim.sh */
#!/bin/sh
# build and run the divsqrt testbench with Verilator, pass only if the log says so

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_divsqrt

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f all.f -o "sim_$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# assertion errors must not stop the run early, the testbench counts them
./obj_dir/"sim_$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

/* verif/tb_divsqrt.sv */
// divsqrt testbench: lfsr stimulus, reference model and in-order scoreboard on the top level
`timescale 1ns/1ns
`default_nettype none

`include "divsqrt_defines.svh"

module tb_divsqrt;
  import divsqrt_op_pkg::*;
  import divsqrt_pipe_pkg::*;

  localparam int CLK_HALF  = 20;
  localparam int NUM_OPS   = 74;  // ops issued over all tests
  localparam int WD_CYCLES =
    NUM_OPS * (`DS_DIV_STEPS + `DS_IN_REGS + `DS_OUT_REGS + 8) + 200;

  // dut ports
  logic       clk_i;
  logic       arst_n_i;
  ds_word_t   opa_i;
  ds_word_t   opb_i;
  ds_op_e     op_i;
  ds_tag_t    tag_i;
  logic       in_valid_i;
  logic       in_ready_o;
  ds_word_t   result_o;
  ds_status_t status_o;
  ds_tag_t    tag_o;
  logic       out_valid_o;
  logic       out_ready_i;
  logic       flush_i;
  logic       busy_o;

  // scoreboard state
  ds_out_payload_t exp_q[$];  // expected results, input order
  ds_out_payload_t exp_head;
  logic [31:0]     lfsr_q     = 32'h9b9b_bf2f;
  int              errors     = 0;
  int              checks     = 0;
  int              tests      = 0;
  int              ready_mode = 0;  // 0 always ready, 1 lfsr, 2 stalled
  ds_tag_t         next_tag   = '0;

  divsqrt_top dut_i (.*);

  initial clk_i = 1'b0;
  always #CLK_HALF clk_i = ~clk_i;

  // ----------------------------------------------------------
  // random source and reference model
  // ----------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};  // one step per bit
    end
    return v;
  endfunction

  // largest r with r*r <= a, built msb first
  function automatic ds_word_t isqrt(input ds_word_t a);
    ds_word_t r;
    ds_word_t t;
    r = '0;
    for (int i = `DS_WIDTH/2 - 1; i >= 0; i--) begin
      t = r | (ds_word_t'(1) << i);
      if (64'(t) * 64'(t) <= 64'(a)) begin
        r = t;
      end
    end
    return r;
  endfunction

  function automatic ds_out_payload_t ref_model(input ds_op_e op, input ds_word_t a,
                                                input ds_word_t b, input ds_tag_t tag);
    ds_out_payload_t e;
    e.tag       = tag;
    e.status.dz = 1'b0;
    if (op == SQRT) begin
      e.result    = isqrt(a);
      e.status.nx = (64'(e.result) * 64'(e.result)) != 64'(a);  // not a perfect square
    end else if (b == '0) begin
      e.result    = '1;
      e.status.dz = 1'b1;
      e.status.nx = 1'b0;
    end else begin
      e.result    = a / b;
      e.status.nx = (a % b) != '0;
    end
    return e;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    checks++;
    assert (act_v == exp_v) else begin
      $display("FAILED %0t %s expected %h got %h", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  // ----------------------------------------------------------
  // monitor, sampled mid cycle
  // ----------------------------------------------------------
  always @(negedge clk_i) begin
    if (arst_n_i && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t: result with tag %h arrived but none was expected",
                 $time, tag_o);
        errors++;
      end else begin
        exp_head = exp_q.pop_front();
        check_field("result_o", exp_head.result, result_o);
        check_field("status_o", 32'(exp_head.status), 32'(status_o));
        check_field("tag_o", 32'(exp_head.tag), 32'(tag_o));
      end
    end
    if (flush_i) begin
      exp_q.delete();  // nothing in flight comes back
    end else if (arst_n_i && in_valid_i && in_ready_o) begin
      exp_q.push_back(ref_model(op_i, opa_i, opb_i, tag_i));
    end
  end

  // ----------------------------------------------------------
  // drivers
  // ----------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
    case (ready_mode)
      0:       out_ready_i = 1'b1;
      1:       out_ready_i = (rand_bits(1) != 0);
      default: out_ready_i = 1'b0;
    endcase
  endtask

  task automatic send_op(input ds_op_e op, input ds_word_t a, input ds_word_t b);
    logic taken;
    opa_i      = a;
    opb_i      = b;
    op_i       = op;
    tag_i      = next_tag;
    in_valid_i = 1'b1;
    taken      = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = in_ready_o;
      next_cycle();
    end
    in_valid_i = 1'b0;
    next_tag++;
  endtask

  // wait until every expected result is back and the unit is idle
  task automatic drain();
    @(negedge clk_i);
    while (exp_q.size() != 0 || busy_o) begin
      next_cycle();
      @(negedge clk_i);
    end
    next_cycle();
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("test %-12s %s, %0d errors", name, (errors == err0) ? "ok" : "bad",
             errors - err0);
  endtask

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    int err0;
    arst_n_i    = 1'b0;
    opa_i       = '0;
    opb_i       = '0;
    op_i        = DIV;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    flush_i     = 1'b0;
    repeat (5) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;

    err0 = errors;  // idle outputs straight after reset
    @(negedge clk_i);
    check_field("out_valid_o", 0, 32'(out_valid_o));
    check_field("busy_o", 0, 32'(busy_o));
    check_field("in_ready_o", 1, 32'(in_ready_o));
    next_cycle();
    end_test("reset", err0);

    err0 = errors;
    send_op(DIV, 32'd100, 32'd10);
    send_op(DIV, 32'd7, 32'd1);
    send_op(DIV, 32'd0, 32'd5);
    send_op(DIV, 32'd5, 32'd7);
    send_op(DIV, '1, 32'd1);
    send_op(DIV, '1, '1);
    send_op(DIV, 32'h8000_0000, 32'd3);
    send_op(DIV, 32'd12345, 32'd0);  // divide by zero
    send_op(DIV, 32'd0, 32'd0);
    repeat (12) send_op(DIV, rand_bits(32), rand_bits(32) >> rand_bits(5));
    drain();
    end_test("division", err0);

    err0 = errors;
    send_op(SQRT, 32'd0, '0);
    send_op(SQRT, 32'd1, '0);
    send_op(SQRT, '1, '0);
    send_op(SQRT, 32'd144, '0);
    send_op(SQRT, 32'hfffe_0001, '0);  // 65535 squared
    repeat (10) send_op(SQRT, rand_bits(32), rand_bits(32));
    drain();
    end_test("sqrt", err0);

    err0 = errors;
    ready_mode = 1;  // random back-pressure
    repeat (16) send_op(ds_op_e'(rand_bits(1)), rand_bits(32), rand_bits(32) >> rand_bits(4));
    drain();
    ready_mode = 2;  // long stall, second result parks in the control block
    send_op(DIV, rand_bits(32), '0);
    send_op(SQRT, rand_bits(32), '0);
    send_op(DIV, rand_bits(32), rand_bits(8) | 32'd1);
    repeat (`DS_SQRT_STEPS + 4) next_cycle();  // sqrt done behind the full output stage
    ready_mode = 1;
    drain();
    ready_mode = 0;
    end_test("backpressure", err0);

    err0 = errors;  // short ops back to back
    repeat (6) begin
      send_op(SQRT, rand_bits(12), '0);
      send_op(DIV, rand_bits(32), '0);
    end
    drain();
    end_test("tags", err0);

    err0 = errors;
    ready_mode = 2;  // pile up work, then drop it
    send_op(DIV, rand_bits(32), 32'd3);
    send_op(SQRT, rand_bits(32), '0);
    send_op(DIV, rand_bits(32), 32'd9);
    flush_i = 1'b1;
    @(negedge clk_i);
    ready_mode = 0;
    next_cycle();
    flush_i = 1'b0;
    @(negedge clk_i);
    check_field("busy_o", 0, 32'(busy_o));
    check_field("out_valid_o", 0, 32'(out_valid_o));
    next_cycle();
    send_op(DIV, 32'd1000, 32'd7);
    send_op(SQRT, 32'd99, '0);
    send_op(DIV, rand_bits(32), rand_bits(16));
    send_op(SQRT, rand_bits(32), '0);
    drain();
    end_test("flush", err0);

    errors += dut_i.u_chk.fail_cnt;
    $display("tests %0d, checks %0d, protocol failures %0d, errors %0d",
             tests, checks, dut_i.u_chk.fail_cnt, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog, bound by the slowest op per issued item
  initial begin
    #(WD_CYCLES * 2 * CLK_HALF);
    $display("timeout: run did not finish within %0d cycles", WD_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/divsqrt_chk.sv */
// divsqrt protocol checker: output hold, busy and flush rules at the top level ports
`timescale 1ns/1ns
`default_nettype none

`include "divsqrt_defines.svh"

module divsqrt_chk (
  input logic                     clk_i,
  input logic                     arst_n_i,
  input logic                     flush_i,
  input logic                     out_valid_i,
  input logic                     out_ready_i,
  input logic                     busy_i,
  input logic [`DS_WIDTH-1:0]     out_result_i,
  input logic [1:0]               out_status_i,
  input logic [`DS_TAG_WIDTH-1:0] out_tag_i
);

  int fail_cnt = 0;  // picked up by the testbench at the end

  // ----------------------------------------------------------
  // output side
  // ----------------------------------------------------------
  // refused result stays put until taken
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_i && !out_ready_i && !flush_i |=> out_valid_i && busy_i &&
      $stable(out_result_i) && $stable(out_status_i) && $stable(out_tag_i))
    else begin
      $error("output changed while refused");
      fail_cnt++;
    end

  a_busy_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_i |-> busy_i)  // a visible result is still in flight
    else begin
      $error("out_valid high with busy low");
      fail_cnt++;
    end

  // flush drops everything in one cycle
  a_flush_clear: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> !out_valid_i)
    else begin
      $error("out_valid high after flush");
      fail_cnt++;
    end

endmodule

bind divsqrt_top divsqrt_chk u_chk (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .flush_i      (flush_i),
  .out_valid_i  (out_valid_o),
  .out_ready_i  (out_ready_i),
  .busy_i       (busy_o),
  .out_result_i (result_o),
  .out_status_i (status_o),
  .out_tag_i    (tag_o)
);

`default_nettype wire

/* hw/divsqrt_top.sv */
// divsqrt top: input pipeline, control, iterative core and output pipeline on plain ports
`timescale 1ns/1ns
`default_nettype none

`include "divsqrt_defines.svh"

module divsqrt_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  divsqrt_op_pkg::ds_word_t   opa_i,
  input  divsqrt_op_pkg::ds_word_t   opb_i,
  input  divsqrt_op_pkg::ds_op_e     op_i,
  input  divsqrt_pipe_pkg::ds_tag_t  tag_i,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  output divsqrt_op_pkg::ds_word_t   result_o,
  output divsqrt_op_pkg::ds_status_t status_o,
  output divsqrt_pipe_pkg::ds_tag_t  tag_o,
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  input  logic                       flush_i,
  output logic                       busy_o
);
  import divsqrt_pipe_pkg::*;

  ds_in_payload_t  in_data, ctrl_in_data;    // ports side / control side
  ds_out_payload_t ctrl_out_data, out_data;
  logic            ctrl_in_valid, ctrl_in_ready;
  logic            ctrl_out_valid, ctrl_out_ready;
  logic            in_busy, ctrl_busy, out_busy;

  divsqrt_core_if u_core_if ();

  // pack the request
  assign in_data.opa = opa_i;
  assign in_data.opb = opb_i;
  assign in_data.op  = op_i;
  assign in_data.tag = tag_i;

  divsqrt_pipe_regs #(
    .payload_t (ds_in_payload_t),
    .NUM_REGS  (`DS_IN_REGS)
  ) u_in_pipe (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush_i),
    .in_data_i   (in_data),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_data_o  (ctrl_in_data),
    .out_valid_o (ctrl_in_valid),
    .out_ready_i (ctrl_in_ready),
    .busy_o      (in_busy)
  );

  divsqrt_ctrl u_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush_i),
    .in_data_i   (ctrl_in_data),
    .in_valid_i  (ctrl_in_valid),
    .in_ready_o  (ctrl_in_ready),
    .out_data_o  (ctrl_out_data),
    .out_valid_o (ctrl_out_valid),
    .out_ready_i (ctrl_out_ready),
    .busy_o      (ctrl_busy),
    .core_if     (u_core_if.ctrl)
  );

  divsqrt_iter u_iter (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .core_if  (u_core_if.core)
  );

  divsqrt_pipe_regs #(
    .payload_t (ds_out_payload_t),
    .NUM_REGS  (`DS_OUT_REGS)
  ) u_out_pipe (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush_i),
    .in_data_i   (ctrl_out_data),
    .in_valid_i  (ctrl_out_valid),
    .in_ready_o  (ctrl_out_ready),
    .out_data_o  (out_data),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (out_busy)
  );

  // unpack the response
  assign result_o = out_data.result;
  assign status_o = out_data.status;
  assign tag_o    = out_data.tag;
  assign busy_o   = in_busy | ctrl_busy | out_busy;  // anything in flight

endmodule

`default_nettype wire

/* hw/divsqrt_iter.sv */
// divsqrt iterative core: restoring unsigned divide and integer square root, one bit per cycle
`timescale 1ns/1ns
`default_nettype none

`include "divsqrt_defines.svh"

module divsqrt_iter (
  input  logic         clk_i,
  input  logic         arst_n_i,
  divsqrt_core_if.core core_if
);
  import divsqrt_op_pkg::*;

  localparam int unsigned W     = `DS_WIDTH;
  localparam int unsigned CNT_W = $clog2(`DS_DIV_STEPS + 1);

  // control
  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;     // steps left, last step when 1
  logic             last;      // final step this cycle
  logic             start_dz;  // divisor zero seen at start
  // datapath
  ds_op_e   op_q;
  logic     dz_q;
  ds_word_t rem_q;   // partial remainder
  ds_word_t work_q;  // div: dividend out, quotient in; sqrt: radicand out
  ds_word_t opb_q;   // div: divisor; sqrt: partial root
  // one restoring step
  logic [W+1:0] shift_val;  // remainder with next operand bits
  logic [W+1:0] sub_val;    // divisor or trial root
  logic [W+2:0] diff;       // msb is the borrow
  logic         take;       // trial fits, result bit is 1
  ds_word_t     rem_n;
  ds_word_t     work_n;
  ds_word_t     opb_n;

  assign start_dz = (core_if.op == DIV) && (core_if.opb == '0);

  // ----------------------------------------------------------
  // step logic
  // ----------------------------------------------------------
  always_comb begin
    if (op_q == SQRT) begin
      shift_val = {rem_q, work_q[W-1 -: 2]};  // two radicand bits per step
      sub_val   = {opb_q, 2'b01};             // 4*root + 1
    end else begin
      shift_val = {1'b0, rem_q, work_q[W-1]};
      sub_val   = {2'b00, opb_q};
    end
    diff  = {1'b0, shift_val} - {1'b0, sub_val};
    take  = ~diff[W+2];
    // remainder stays below divisor / 2*root+1, fits W bits either way
    rem_n = take ? diff[W-1:0] : shift_val[W-1:0];
    if (op_q == SQRT) begin
      work_n = {work_q[W-3:0], 2'b00};
      opb_n  = {opb_q[W-2:0], take};  // root grows one bit
    end else begin
      work_n = {work_q[W-2:0], take};  // quotient bit in at the bottom
      opb_n  = opb_q;
    end
  end

  // done and result come from the last step itself, not from its register
  assign last         = busy_q && (cnt_q == CNT_W'(1));
  assign core_if.done = last;

  always_comb begin
    if (dz_q) begin
      core_if.result    = '1;  // all ones on divide by zero
      core_if.status.dz = 1'b1;
      core_if.status.nx = 1'b0;
    end else begin
      core_if.result    = (op_q == SQRT) ? opb_n : work_n;
      core_if.status.dz = 1'b0;
      core_if.status.nx = (rem_n != '0);  // leftover remainder
    end
  end

  // ----------------------------------------------------------
  // registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (core_if.abort) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (core_if.start) begin
      busy_q <= 1'b1;
      if (start_dz) begin
        cnt_q <= CNT_W'(1);  // finishes next cycle
      end else if (core_if.op == SQRT) begin
        cnt_q <= CNT_W'(`DS_SQRT_STEPS);
      end else begin
        cnt_q <= CNT_W'(`DS_DIV_STEPS);
      end
    end else if (busy_q) begin
      busy_q <= ~last;
      cnt_q  <= cnt_q - CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (core_if.start) begin
      op_q   <= core_if.op;
      dz_q   <= start_dz;
      rem_q  <= '0;
      work_q <= core_if.opa;
      opb_q  <= (core_if.op == SQRT) ? '0 : core_if.opb;  // root starts at 0
    end else if (busy_q) begin
      rem_q  <= rem_n;
      work_q <= work_n;
      opb_q  <= opb_n;
    end
  end

endmodule

`default_nettype wire

/* hw/divsqrt_ctrl.sv */
// divsqrt control: starts one core op at a time, tracks its tag and parks a stalled result
`timescale 1ns/1ns
`default_nettype none

module divsqrt_ctrl (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              flush_i,
  input  divsqrt_pipe_pkg::ds_in_payload_t  in_data_i,
  input  logic                              in_valid_i,
  output logic                              in_ready_o,
  output divsqrt_pipe_pkg::ds_out_payload_t out_data_o,
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output logic                              busy_o,
  divsqrt_core_if.ctrl                      core_if
);
  import divsqrt_op_pkg::*;
  import divsqrt_pipe_pkg::*;

  ds_state_e  state_q, state_d;
  logic       op_start;       // input accepted and sent to the core
  logic       hold_load;      // park the core result this cycle
  logic       data_held;      // hold register drives the output
  ds_tag_t    tag_q;          // tag of the op in the core
  ds_word_t   held_result_q;
  ds_status_t held_status_q;

  // ----------------------------------------------------------
  // state machine
  // ----------------------------------------------------------
  always_comb begin
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    hold_load   = 1'b0;
    data_held   = 1'b0;
    busy_o      = 1'b0;
    state_d     = state_q;

    unique case (state_q)
      IDLE: begin
        in_ready_o = 1'b1;  // core is free
        if (in_valid_i) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        busy_o = 1'b1;
        if (core_if.done) begin
          out_valid_o = 1'b1;  // core outputs go straight out
          if (out_ready_i) begin
            state_d    = IDLE;
            in_ready_o = 1'b1;  // next op may start right away
            if (in_valid_i) begin
              state_d = BUSY;
            end
          end else begin
            hold_load = 1'b1;  // downstream stalled, park it
            state_d   = HOLD;
          end
        end
      end
      HOLD: begin
        busy_o      = 1'b1;
        data_held   = 1'b1;
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          state_d    = IDLE;
          in_ready_o = 1'b1;
          if (in_valid_i) begin
            state_d = BUSY;
          end
        end
      end
      default: state_d = IDLE;
    endcase

    // flush wins over everything
    if (flush_i) begin
      busy_o      = 1'b0;
      out_valid_o = 1'b0;
      state_d     = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------
  // core request
  // ----------------------------------------------------------
  assign op_start      = in_valid_i & in_ready_o & ~flush_i;
  assign core_if.start = op_start;
  assign core_if.op    = in_data_i.op;
  assign core_if.opa   = in_data_i.opa;
  assign core_if.opb   = in_data_i.opb;
  assign core_if.abort = flush_i;  // running op is dropped

  // tag follows the op through the core, result registers park a refused result
  always_ff @(posedge clk_i) begin
    if (op_start) begin
      tag_q <= in_data_i.tag;
    end
    if (hold_load) begin
      held_result_q <= core_if.result;
      held_status_q <= core_if.status;
    end
  end

  // output select, parked data first
  assign out_data_o.result = data_held ? held_result_q : core_if.result;
  assign out_data_o.status = data_held ? held_status_q : core_if.status;
  assign out_data_o.tag    = tag_q;

endmodule

`default_nettype wire

/* hw/divsqrt_pipe_regs.sv */
// divsqrt register pipeline: valid/ready enable-register chain with flush, any payload type
`timescale 1ns/1ns
`default_nettype none

module divsqrt_pipe_regs #(
  parameter type         payload_t = logic,
  parameter int unsigned NUM_REGS  = 1
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flush_i,     // drops every item in the chain
  input  payload_t in_data_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t out_data_o,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output logic     busy_o       // any stage holds a valid item
);

  // index i is the signal after i stages, index 0 is the input side
  payload_t          data_q  [0:NUM_REGS];
  logic              valid_q [0:NUM_REGS];
  logic              ready   [0:NUM_REGS];  // combinational, runs backwards
  logic [NUM_REGS:0] busy_vec;              // bit 0 is the unregistered input

  assign data_q[0]   = in_data_i;
  assign valid_q[0]  = in_valid_i;
  assign busy_vec[0] = 1'b0;  // input not yet taken, not in flight
  assign in_ready_o  = ready[0];

  // ----------------------------------------------------------
  // stages
  // ----------------------------------------------------------
  for (genvar i = 0; i < NUM_REGS; i++) begin : gen_stage
    // advance when the next stage moves on or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;  // sync clear beats a transfer
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    // payload only moves with a real item
    always_ff @(posedge clk_i) begin
      if (ready[i] && valid_q[i]) begin
        data_q[i+1] <= data_q[i];
      end
    end

    assign busy_vec[i+1] = valid_q[i+1];
  end

  // downstream ready enters at the far end
  assign ready[NUM_REGS] = out_ready_i;
  assign out_data_o      = data_q[NUM_REGS];
  assign out_valid_o     = valid_q[NUM_REGS];
  assign busy_o          = |busy_vec;

endmodule

`default_nettype wire

/* hw/divsqrt_core_if.sv */
// divsqrt core interface: start/done link between the control block and the iterative core
`timescale 1ns/1ns
`default_nettype none

interface divsqrt_core_if;
  import divsqrt_op_pkg::*;

  // request side, driven by the control block
  logic     start;  // one cycle pulse, core idle
  ds_op_e   op;
  ds_word_t opa;
  ds_word_t opb;
  logic     abort;  // flush, core back to idle at once

  // response side, driven by the core
  logic       done;    // one cycle pulse on the last step
  ds_word_t   result;  // valid with done
  ds_status_t status;  // valid with done

  modport ctrl (
    output start, op, opa, opb, abort,
    input  done, result, status
  );

  modport core (
    input  start, op, opa, opb, abort,
    output done, result, status
  );

endinterface

`default_nettype wire

/* hw/divsqrt_pipe_pkg.sv */
// divsqrt pipeline package: payloads of the register pipelines and the control states
`default_nettype none

`include "divsqrt_defines.svh"

package divsqrt_pipe_pkg;

  typedef logic [`DS_TAG_WIDTH-1:0] ds_tag_t;  // user tag, returned unchanged

  // ----------------------------------------------------------
  // register pipeline payloads
  // ----------------------------------------------------------
  typedef struct packed {
    divsqrt_op_pkg::ds_word_t opa;  // dividend or radicand
    divsqrt_op_pkg::ds_word_t opb;  // divisor
    divsqrt_op_pkg::ds_op_e   op;
    ds_tag_t                  tag;
  } ds_in_payload_t;

  typedef struct packed {
    divsqrt_op_pkg::ds_word_t   result;
    divsqrt_op_pkg::ds_status_t status;
    ds_tag_t                    tag;
  } ds_out_payload_t;

  // control states
  typedef enum logic [1:0] {
    IDLE = 2'd0,  // waiting for work
    BUSY = 2'd1,  // core running
    HOLD = 2'd2   // result parked, downstream stalled
  } ds_state_e;

endpackage

`default_nettype wire

/* hw/divsqrt_op_pkg.sv */
// divsqrt operation package: operation select, status flags and data word types
`default_nettype none

`include "divsqrt_defines.svh"

package divsqrt_op_pkg;

  // ----------------------------------------------------------
  // arithmetic types
  // ----------------------------------------------------------
  typedef logic [`DS_WIDTH-1:0] ds_word_t;  // operand and result word

  // operation select
  typedef enum logic {
    DIV  = 1'b0,  // opa / opb, quotient
    SQRT = 1'b1   // floor(sqrt(opa)), opb ignored
  } ds_op_e;

  // status flags, subset of the usual fp flags
  typedef struct packed {
    logic dz;  // divide by zero
    logic nx;  // inexact, remainder was nonzero
  } ds_status_t;

endpackage

`default_nettype wire

/* include/divsqrt_defines.svh */
// divsqrt defines: datapath widths, iteration counts, tag width and pipeline depths
`ifndef DIVSQRT_DEFINES_SVH
`define DIVSQRT_DEFINES_SVH

// ----------------------------------------------------------
// datapath
// ----------------------------------------------------------
`define DS_WIDTH 32        // operand and result width

// iterative core latency, one result bit per cycle
`define DS_DIV_STEPS 32    // one quotient bit per step
`define DS_SQRT_STEPS 16   // one root bit per step, two radicand bits consumed

// ----------------------------------------------------------
// handshake side
// ----------------------------------------------------------
`define DS_TAG_WIDTH 4     // user tag carried alongside each op

// register stages around the core
`define DS_IN_REGS 1       // between the input ports and the control block
`define DS_OUT_REGS 1      // between the control block and the output ports

`endif
